//--- Makefile
# Verilator build and run of the external subsystem testbench

VERILATOR ?= verilator
TOP       ?= tb_ext_subsystem
FILELIST  ?= compile.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -Wno-fatal -j 0

SOURCES := $(shell grep -v '^+' $(FILELIST))
SIM_BIN := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	-$(SIM_BIN) 2>&1 | tee $(LOG)
	@if grep -q "TEST FAIL" $(LOG) || ! grep -q "TEST PASS" $(LOG); then \
		echo "simulation reported a failure, see $(LOG)"; exit 1; \
	fi

clean:
	rm -rf $(BUILD_DIR) $(LOG)

//--- accel/vector_scaler.sv
/* Vector scaler: dst[i] = src[i] * FACTOR, low 32 bits kept. One access
   in flight at a time; completion and CTRL rules match the copy engine. */
`timescale 1ns/1ps

module vector_scaler (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               reg_sel_i,
  input  logic                               reg_write_i,
  input  logic [ext_pkg::PERIPH_SEL_LSB-1:0] reg_offset_i,
  input  logic [ext_pkg::DATA_W-1:0]         reg_wdata_i,
  output logic [ext_pkg::DATA_W-1:0]         reg_rdata_o,
  output logic                               done_irq_o,
  mem_bus_if.master                          mem
);

  ext_pkg::engine_state_e     state_q;
  logic [ext_pkg::ADDR_W-1:0] src_q, dst_q, rd_addr_q, wr_addr_q;
  logic [ext_pkg::LEN_W-1:0]  len_q, remain_q;
  logic [ext_pkg::DATA_W-1:0] factor_q, prod_q;
  logic                       done_q;
  logic                       busy;
  logic                       wr_en;

  assign busy  = (state_q != ext_pkg::IDLE);
  assign wr_en = reg_sel_i && reg_write_i;

  always_ff @(posedge clk_i) begin
    if (wr_en && reg_offset_i == ext_pkg::REG_SRC) src_q <= reg_wdata_i;
    if (wr_en && reg_offset_i == ext_pkg::REG_DST) dst_q <= reg_wdata_i;
    if (wr_en && reg_offset_i == ext_pkg::REG_LEN) len_q <= reg_wdata_i[ext_pkg::LEN_W-1:0];
    if (wr_en && reg_offset_i == ext_pkg::REG_FACTOR) factor_q <= reg_wdata_i;
    // Product taken as the word arrives
    if (state_q == ext_pkg::READ_WAIT && mem.rvalid) prod_q <= mem.rdata * factor_q;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ext_pkg::IDLE;
      done_q  <= 1'b0;
    end else begin
      case (state_q)
        ext_pkg::IDLE: if (wr_en && reg_offset_i == ext_pkg::REG_CTRL) begin
          done_q    <= 1'b0;
          rd_addr_q <= src_q;
          wr_addr_q <= dst_q;
          remain_q  <= len_q;
          state_q   <= (len_q == '0) ? ext_pkg::DONE : ext_pkg::READ_REQ;
        end
        ext_pkg::READ_REQ:  if (mem.gnt) state_q <= ext_pkg::READ_WAIT;
        ext_pkg::READ_WAIT: if (mem.rvalid) state_q <= ext_pkg::WRITE_REQ;
        ext_pkg::WRITE_REQ: if (mem.gnt) begin
          rd_addr_q <= rd_addr_q + 32'd4;
          wr_addr_q <= wr_addr_q + 32'd4;
          remain_q  <= remain_q - 1'b1;
          state_q   <= (remain_q == 1) ? ext_pkg::DONE : ext_pkg::READ_REQ;
        end
        default: begin
          done_q  <= 1'b1;
          state_q <= ext_pkg::IDLE;
        end
      endcase
    end
  end

  assign mem.req    = (state_q == ext_pkg::READ_REQ) || (state_q == ext_pkg::WRITE_REQ);
  assign mem.we     = (state_q == ext_pkg::WRITE_REQ);
  assign mem.addr   = mem.we ? wr_addr_q : rd_addr_q;
  assign mem.wdata  = prod_q;
  assign done_irq_o = done_q;

  always_comb begin
    case (reg_offset_i)
      ext_pkg::REG_SRC:    reg_rdata_o = src_q;
      ext_pkg::REG_DST:    reg_rdata_o = dst_q;
      ext_pkg::REG_LEN:    reg_rdata_o = {{(ext_pkg::DATA_W-ext_pkg::LEN_W){1'b0}}, len_q};
      ext_pkg::REG_STATUS: reg_rdata_o = {{(ext_pkg::DATA_W-2){1'b0}}, done_q, busy};
      ext_pkg::REG_FACTOR: reg_rdata_o = factor_q;
      default:             reg_rdata_o = '0;
    endcase
  end

endmodule

//--- bus/mem_arbiter.sv
/* Round-robin arbiter for three masters in front of one memory. Priority
   starts after the last winner; responses are steered by the returned id. */
`timescale 1ns/1ps

module mem_arbiter (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  mem_bus_if.slave                        m0,
  mem_bus_if.slave                        m1,
  mem_bus_if.slave                        m2,
  mem_bus_if.master                       mem,
  output logic [ext_pkg::MASTER_ID_W-1:0] id_o,
  input  logic [ext_pkg::MASTER_ID_W-1:0] resp_id_i
);

  logic [ext_pkg::N_MASTERS-1:0]   req_vec;
  logic [ext_pkg::N_MASTERS-1:0]   we_vec;
  logic [ext_pkg::ADDR_W-1:0]      addr_vec  [ext_pkg::N_MASTERS];
  logic [ext_pkg::DATA_W-1:0]      wdata_vec [ext_pkg::N_MASTERS];
  logic [ext_pkg::MASTER_ID_W-1:0] last_q;
  logic [ext_pkg::MASTER_ID_W-1:0] winner;
  logic                            found;

  assign req_vec   = {m2.req, m1.req, m0.req};
  assign we_vec    = {m2.we, m1.we, m0.we};
  assign addr_vec  = '{m0.addr, m1.addr, m2.addr};
  assign wdata_vec = '{m0.wdata, m1.wdata, m2.wdata};

  always_comb begin
    int cand;
    found  = 1'b0;
    winner = '0;
    for (int i = 1; i <= ext_pkg::N_MASTERS; i++) begin
      cand = (int'(last_q) + i) % ext_pkg::N_MASTERS;
      if (!found && req_vec[cand]) begin
        found  = 1'b1;
        winner = cand[ext_pkg::MASTER_ID_W-1:0];
      end
    end
  end

  // Master 0 gets the first turn out of reset
  always_ff @(posedge clk_i) begin
    if (!rst_n_i) last_q <= ext_pkg::MASTER_ID_W'(ext_pkg::N_MASTERS - 1);
    else if (mem.req && mem.gnt) last_q <= winner;
  end

  assign mem.req   = found;
  assign mem.we    = we_vec[winner];
  assign mem.addr  = addr_vec[winner];
  assign mem.wdata = wdata_vec[winner];
  assign id_o      = winner;

  assign m0.gnt = mem.gnt && found && (winner == ext_pkg::HOST_ID);
  assign m1.gnt = mem.gnt && found && (winner == ext_pkg::DMA_ID);
  assign m2.gnt = mem.gnt && found && (winner == ext_pkg::SCALER_ID);

  assign m0.rvalid = mem.rvalid && (resp_id_i == ext_pkg::HOST_ID);
  assign m1.rvalid = mem.rvalid && (resp_id_i == ext_pkg::DMA_ID);
  assign m2.rvalid = mem.rvalid && (resp_id_i == ext_pkg::SCALER_ID);
  assign m0.rdata  = mem.rdata;
  assign m1.rdata  = mem.rdata;
  assign m2.rdata  = mem.rdata;

endmodule

//--- bus/slow_memory.sv
/* Word memory, always granting. Reads come back exactly MEM_LATENCY cycles
   after the grant, tagged with the requester id. Contents are not reset. */
`timescale 1ns/1ps

module slow_memory (
  input  logic                            clk_i,
  input  logic                            rst_n_i,
  input  logic [ext_pkg::MASTER_ID_W-1:0] id_i,
  output logic [ext_pkg::MASTER_ID_W-1:0] resp_id_o,
  mem_bus_if.slave                        mem
);

  logic [ext_pkg::DATA_W-1:0]      mem_q  [ext_pkg::MEM_WORDS];
  logic [ext_pkg::MEM_LATENCY-1:0] valid_q;
  logic [ext_pkg::DATA_W-1:0]      data_q [ext_pkg::MEM_LATENCY];
  logic [ext_pkg::MASTER_ID_W-1:0] id_q   [ext_pkg::MEM_LATENCY];
  logic [ext_pkg::MEM_IDX_W-1:0]   word_idx;

  assign word_idx = mem.addr[ext_pkg::MEM_IDX_W+1:2];
  assign mem.gnt  = mem.req;

  always_ff @(posedge clk_i) begin
    if (mem.req && mem.we) mem_q[word_idx] <= mem.wdata;
    data_q[0] <= mem_q[word_idx];
    id_q[0]   <= id_i;
    for (int i = 1; i < ext_pkg::MEM_LATENCY; i++) begin
      data_q[i] <= data_q[i-1];
      id_q[i]   <= id_q[i-1];
    end
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) valid_q <= '0;
    else valid_q <= {valid_q[ext_pkg::MEM_LATENCY-2:0], mem.req && !mem.we};
  end

  assign mem.rvalid = valid_q[ext_pkg::MEM_LATENCY-1];
  assign mem.rdata  = data_q[ext_pkg::MEM_LATENCY-1];
  assign resp_id_o  = id_q[ext_pkg::MEM_LATENCY-1];

endmodule

//--- common/ext_pkg.sv
/* Shared widths, address map and register offsets of the external subsystem.
   All memory accesses are full 32-bit words, so byte enables do not exist. */
package ext_pkg;

  localparam int ADDR_W      = 32;
  localparam int DATA_W      = 32;
  localparam int MEM_WORDS   = 1024;
  localparam int MEM_IDX_W   = 10;
  localparam int N_MASTERS   = 3;
  localparam int MASTER_ID_W = 2;
  localparam int MEM_LATENCY = 2;
  localparam int LEN_W       = 16;

  // Bus master ids, also the arbiter input index
  localparam logic [MASTER_ID_W-1:0] HOST_ID   = 2'd0;
  localparam logic [MASTER_ID_W-1:0] DMA_ID    = 2'd1;
  localparam logic [MASTER_ID_W-1:0] SCALER_ID = 2'd2;

  // Peripheral windows on the register bus
  localparam logic [ADDR_W-1:0] DMA_BASE    = 32'h0000_0000;
  localparam logic [ADDR_W-1:0] SCALER_BASE = 32'h0000_0100;
  localparam int PERIPH_SEL_LSB = 8;

  localparam logic [PERIPH_SEL_LSB-1:0] REG_SRC    = 8'h00;
  localparam logic [PERIPH_SEL_LSB-1:0] REG_DST    = 8'h04;
  localparam logic [PERIPH_SEL_LSB-1:0] REG_LEN    = 8'h08;
  localparam logic [PERIPH_SEL_LSB-1:0] REG_CTRL   = 8'h0C;
  localparam logic [PERIPH_SEL_LSB-1:0] REG_STATUS = 8'h10;
  localparam logic [PERIPH_SEL_LSB-1:0] REG_FACTOR = 8'h14;

  typedef enum logic [2:0] {IDLE, READ_REQ, READ_WAIT, WRITE_REQ, DONE} engine_state_e;

  typedef enum logic [1:0] {SEL_DMA, SEL_SCALER, SEL_NONE} periph_sel_e;

endpackage

//--- common/mem_bus_if.sv
/* Request/grant/read-valid word bus. A read answers with one rvalid
   MEM_LATENCY cycles after its grant, a write answers with nothing. */
`timescale 1ns/1ps

interface mem_bus_if;

  logic                       req;
  logic                       we;
  logic [ext_pkg::ADDR_W-1:0] addr;
  logic [ext_pkg::DATA_W-1:0] wdata;
  logic                       gnt;
  logic                       rvalid;
  logic [ext_pkg::DATA_W-1:0] rdata;

  modport master (
    output req, we, addr, wdata,
    input  gnt, rvalid, rdata
  );

  modport slave (
    input  req, we, addr, wdata,
    output gnt, rvalid, rdata
  );

endinterface

//--- compile.f
common/ext_pkg.sv
common/mem_bus_if.sv
bus/slow_memory.sv
bus/mem_arbiter.sv
dma/dma_copy_engine.sv
accel/vector_scaler.sv
src/periph_reg_demux.sv
src/ext_subsystem.sv
test/ext_subsystem_properties.sv
test/tb_ext_subsystem.sv

//--- dma/dma_copy_engine.sv
/* Word copy engine, one outstanding access at a time. A CTRL write while
   busy is dropped; done and the interrupt hold until the next start. */
`timescale 1ns/1ps

module dma_copy_engine (
  input  logic                               clk_i,
  input  logic                               rst_n_i,
  input  logic                               reg_sel_i,
  input  logic                               reg_write_i,
  input  logic [ext_pkg::PERIPH_SEL_LSB-1:0] reg_offset_i,
  input  logic [ext_pkg::DATA_W-1:0]         reg_wdata_i,
  output logic [ext_pkg::DATA_W-1:0]         reg_rdata_o,
  output logic                               done_irq_o,
  mem_bus_if.master                          mem
);

  ext_pkg::engine_state_e     state_q;
  logic [ext_pkg::ADDR_W-1:0] src_q, dst_q, rd_addr_q, wr_addr_q;
  logic [ext_pkg::LEN_W-1:0]  len_q, remain_q;
  logic [ext_pkg::DATA_W-1:0] buf_q;
  logic                       done_q;
  logic                       busy;
  logic                       wr_en;

  assign busy  = (state_q != ext_pkg::IDLE);
  assign wr_en = reg_sel_i && reg_write_i;

  always_ff @(posedge clk_i) begin
    if (wr_en && reg_offset_i == ext_pkg::REG_SRC) src_q <= reg_wdata_i;
    if (wr_en && reg_offset_i == ext_pkg::REG_DST) dst_q <= reg_wdata_i;
    if (wr_en && reg_offset_i == ext_pkg::REG_LEN) len_q <= reg_wdata_i[ext_pkg::LEN_W-1:0];
    if (state_q == ext_pkg::READ_WAIT && mem.rvalid) buf_q <= mem.rdata;
  end

  always_ff @(posedge clk_i) begin
    if (!rst_n_i) begin
      state_q <= ext_pkg::IDLE;
      done_q  <= 1'b0;
    end else begin
      case (state_q)
        ext_pkg::IDLE: if (wr_en && reg_offset_i == ext_pkg::REG_CTRL) begin
          done_q    <= 1'b0;
          rd_addr_q <= src_q;
          wr_addr_q <= dst_q;
          remain_q  <= len_q;
          state_q   <= (len_q == '0) ? ext_pkg::DONE : ext_pkg::READ_REQ;
        end
        ext_pkg::READ_REQ:  if (mem.gnt) state_q <= ext_pkg::READ_WAIT;
        ext_pkg::READ_WAIT: if (mem.rvalid) state_q <= ext_pkg::WRITE_REQ;
        ext_pkg::WRITE_REQ: if (mem.gnt) begin
          rd_addr_q <= rd_addr_q + 32'd4;
          wr_addr_q <= wr_addr_q + 32'd4;
          remain_q  <= remain_q - 1'b1;
          state_q   <= (remain_q == 1) ? ext_pkg::DONE : ext_pkg::READ_REQ;
        end
        default: begin
          done_q  <= 1'b1;
          state_q <= ext_pkg::IDLE;
        end
      endcase
    end
  end

  assign mem.req    = (state_q == ext_pkg::READ_REQ) || (state_q == ext_pkg::WRITE_REQ);
  assign mem.we     = (state_q == ext_pkg::WRITE_REQ);
  assign mem.addr   = mem.we ? wr_addr_q : rd_addr_q;
  assign mem.wdata  = buf_q;
  assign done_irq_o = done_q;

  always_comb begin
    case (reg_offset_i)
      ext_pkg::REG_SRC:    reg_rdata_o = src_q;
      ext_pkg::REG_DST:    reg_rdata_o = dst_q;
      ext_pkg::REG_LEN:    reg_rdata_o = {{(ext_pkg::DATA_W-ext_pkg::LEN_W){1'b0}}, len_q};
      ext_pkg::REG_STATUS: reg_rdata_o = {{(ext_pkg::DATA_W-2){1'b0}}, done_q, busy};
      default:             reg_rdata_o = '0;
    endcase
  end

endmodule

//--- src/ext_subsystem.sv
/* External device subsystem: DMA and scaler on the register bus, sharing
   one slow memory with the host port. intr_o[0] is the DMA, intr_o[1] the scaler. */
`timescale 1ns/1ps

module ext_subsystem (
  input  logic                       clk_i,
  input  logic                       rst_n_i,
  input  logic                       reg_valid_i,
  input  logic                       reg_write_i,
  input  logic [ext_pkg::ADDR_W-1:0] reg_addr_i,
  input  logic [ext_pkg::DATA_W-1:0] reg_wdata_i,
  output logic [ext_pkg::DATA_W-1:0] reg_rdata_o,
  output logic                       reg_error_o,
  input  logic                       host_req_i,
  input  logic                       host_we_i,
  input  logic [ext_pkg::ADDR_W-1:0] host_addr_i,
  input  logic [ext_pkg::DATA_W-1:0] host_wdata_i,
  output logic                       host_gnt_o,
  output logic                       host_rvalid_o,
  output logic [ext_pkg::DATA_W-1:0] host_rdata_o,
  output logic [1:0]                 intr_o
);

  logic                               dma_sel;
  logic                               scaler_sel;
  logic                               reg_write;
  logic [ext_pkg::PERIPH_SEL_LSB-1:0] reg_offset;
  logic [ext_pkg::DATA_W-1:0]         reg_wdata;
  logic [ext_pkg::DATA_W-1:0]         dma_rdata;
  logic [ext_pkg::DATA_W-1:0]         scaler_rdata;
  logic [ext_pkg::MASTER_ID_W-1:0]    mem_id;
  logic [ext_pkg::MASTER_ID_W-1:0]    resp_id;

  mem_bus_if host_bus ();
  mem_bus_if dma_bus ();
  mem_bus_if scaler_bus ();
  mem_bus_if mem_bus ();

  assign host_bus.req   = host_req_i;
  assign host_bus.we    = host_we_i;
  assign host_bus.addr  = host_addr_i;
  assign host_bus.wdata = host_wdata_i;
  assign host_gnt_o     = host_bus.gnt;
  assign host_rvalid_o  = host_bus.rvalid;
  assign host_rdata_o   = host_bus.rdata;

  periph_reg_demux u_demux (
    .reg_valid_i   (reg_valid_i),
    .reg_write_i   (reg_write_i),
    .reg_addr_i    (reg_addr_i),
    .reg_wdata_i   (reg_wdata_i),
    .dma_rdata_i   (dma_rdata),
    .scaler_rdata_i(scaler_rdata),
    .dma_sel_o     (dma_sel),
    .scaler_sel_o  (scaler_sel),
    .reg_write_o   (reg_write),
    .reg_offset_o  (reg_offset),
    .reg_wdata_o   (reg_wdata),
    .reg_rdata_o   (reg_rdata_o),
    .reg_error_o   (reg_error_o)
  );

  dma_copy_engine u_dma (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .reg_sel_i(dma_sel), .reg_write_i(reg_write), .reg_offset_i(reg_offset),
    .reg_wdata_i(reg_wdata), .reg_rdata_o(dma_rdata), .done_irq_o(intr_o[0]),
    .mem(dma_bus.master)
  );

  vector_scaler u_scaler (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .reg_sel_i(scaler_sel), .reg_write_i(reg_write), .reg_offset_i(reg_offset),
    .reg_wdata_i(reg_wdata), .reg_rdata_o(scaler_rdata), .done_irq_o(intr_o[1]),
    .mem(scaler_bus.master)
  );

  mem_arbiter u_arbiter (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .m0(host_bus.slave), .m1(dma_bus.slave), .m2(scaler_bus.slave),
    .mem(mem_bus.master), .id_o(mem_id), .resp_id_i(resp_id)
  );

  slow_memory u_memory (
    .clk_i(clk_i), .rst_n_i(rst_n_i),
    .id_i(mem_id), .resp_id_o(resp_id), .mem(mem_bus.slave)
  );

endmodule

//--- src/periph_reg_demux.sv
/* Register bus decoder. Address bits 8 and up pick the peripheral; an
   unmapped access returns zero data with reg_error_o in the same cycle. */
`timescale 1ns/1ps

module periph_reg_demux (
  input  logic                               reg_valid_i,
  input  logic                               reg_write_i,
  input  logic [ext_pkg::ADDR_W-1:0]         reg_addr_i,
  input  logic [ext_pkg::DATA_W-1:0]         reg_wdata_i,
  input  logic [ext_pkg::DATA_W-1:0]         dma_rdata_i,
  input  logic [ext_pkg::DATA_W-1:0]         scaler_rdata_i,
  output logic                               dma_sel_o,
  output logic                               scaler_sel_o,
  output logic                               reg_write_o,
  output logic [ext_pkg::PERIPH_SEL_LSB-1:0] reg_offset_o,
  output logic [ext_pkg::DATA_W-1:0]         reg_wdata_o,
  output logic [ext_pkg::DATA_W-1:0]         reg_rdata_o,
  output logic                               reg_error_o
);

  localparam int HI = ext_pkg::ADDR_W - 1;
  localparam int LO = ext_pkg::PERIPH_SEL_LSB;

  ext_pkg::periph_sel_e sel;

  always_comb begin
    if (reg_addr_i[HI:LO] == ext_pkg::DMA_BASE[HI:LO]) sel = ext_pkg::SEL_DMA;
    else if (reg_addr_i[HI:LO] == ext_pkg::SCALER_BASE[HI:LO]) sel = ext_pkg::SEL_SCALER;
    else sel = ext_pkg::SEL_NONE;
  end

  assign dma_sel_o    = reg_valid_i && (sel == ext_pkg::SEL_DMA);
  assign scaler_sel_o = reg_valid_i && (sel == ext_pkg::SEL_SCALER);
  assign reg_error_o  = reg_valid_i && (sel == ext_pkg::SEL_NONE);
  assign reg_write_o  = reg_write_i;
  assign reg_offset_o = reg_addr_i[LO-1:0];
  assign reg_wdata_o  = reg_wdata_i;

  always_comb begin
    case (sel)
      ext_pkg::SEL_DMA:    reg_rdata_o = dma_rdata_i;
      ext_pkg::SEL_SCALER: reg_rdata_o = scaler_rdata_i;
      default:             reg_rdata_o = '0;
    endcase
  end

endmodule

//--- test/ext_subsystem_properties.sv
/* Memory bus timing checks, bound into the arbiter and the slow memory.
   Read latency is taken from ext_pkg::MEM_LATENCY. */
`timescale 1ns/1ps

module ext_subsystem_properties (
  input logic                          clk_i,
  input logic                          rst_n_i,
  input logic [ext_pkg::N_MASTERS-1:0] req_i,
  input logic [ext_pkg::N_MASTERS-1:0] gnt_i,
  input logic [ext_pkg::N_MASTERS-1:0] rd_gnt_i,
  input logic [ext_pkg::N_MASTERS-1:0] rvalid_i
);

  one_grant: assert property (@(posedge clk_i) disable iff (!rst_n_i) $onehot0(gnt_i))
    else $error("more than one grant in a cycle");

  grant_needs_req: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    (gnt_i & ~req_i) == '0)
    else $error("grant given to a master without a request");

  // Per port and both ways, so an early, late, spurious or misrouted rvalid fails
  read_latency: assert property (@(posedge clk_i) disable iff (!rst_n_i)
    rvalid_i == $past(rd_gnt_i, ext_pkg::MEM_LATENCY))
    else $error("rvalid not exactly MEM_LATENCY cycles after a read grant");

endmodule

bind mem_arbiter ext_subsystem_properties u_arbiter_props (
  .clk_i(clk_i), .rst_n_i(rst_n_i), .req_i(req_vec),
  .gnt_i({m2.gnt, m1.gnt, m0.gnt}),
  .rd_gnt_i({m2.gnt, m1.gnt, m0.gnt} & ~we_vec),
  .rvalid_i({m2.rvalid, m1.rvalid, m0.rvalid})
);

bind slow_memory ext_subsystem_properties u_memory_props (
  .clk_i(clk_i), .rst_n_i(rst_n_i),
  .req_i({{(ext_pkg::N_MASTERS-1){1'b0}}, mem.req}),
  .gnt_i({{(ext_pkg::N_MASTERS-1){1'b0}}, mem.gnt}),
  .rd_gnt_i({{(ext_pkg::N_MASTERS-1){1'b0}}, mem.req && mem.gnt && !mem.we}),
  .rvalid_i({{(ext_pkg::N_MASTERS-1){1'b0}}, mem.rvalid})
);

//--- test/tb_ext_subsystem.sv
/* Testbench for ext_subsystem. Host reads are scored by a monitor against a
   memory model; engine results are read back through the host port. */
`timescale 1ns/1ps

module tb_ext_subsystem;

  localparam int CLK_PERIOD    = 100;
  localparam int HOST_WORDS    = 16;
  localparam int COPY_LEN      = 24;
  localparam int SCALE_LEN     = 20;
  localparam int ZERO_WORDS    = 8;
  localparam int HOST_IDX      = 0;
  localparam int COPY_SRC      = 64;
  localparam int COPY_DST      = 128;
  localparam int SCALE_SRC     = 192;
  localparam int SCALE_DST     = 256;
  localparam int PAR_COPY_DST  = 320;
  localparam int PAR_SCALE_DST = 384;
  localparam int TOTAL_WORDS   = 3 * HOST_WORDS + 4 * COPY_LEN + 4 * SCALE_LEN + ZERO_WORDS;
  localparam int WATCHDOG_CYCLES = TOTAL_WORDS * 4 * ext_pkg::MEM_LATENCY + 1000;

  logic        clk;
  logic        rst_n;
  logic        reg_valid;
  logic        reg_write;
  logic [31:0] reg_addr;
  logic [31:0] reg_wdata;
  logic [31:0] reg_rdata;
  logic        reg_error;
  logic        host_req;
  logic        host_we;
  logic [31:0] host_addr;
  logic [31:0] host_wdata;
  logic        host_gnt;
  logic        host_rvalid;
  logic [31:0] host_rdata;
  logic [1:0]  intr;

  logic [31:0] model [ext_pkg::MEM_WORDS];
  logic [31:0] exp_q [$];
  int          gnt_cycle_q [$];
  integer      seed = 32'hefb8_5d03;
  int          cycle_cnt = 0;
  int          test_errors;
  int          total_errors;
  int          tests_run;
  int          tests_failed;
  string       test_name;

  ext_subsystem DUT (
    .clk_i(clk), .rst_n_i(rst_n),
    .reg_valid_i(reg_valid), .reg_write_i(reg_write), .reg_addr_i(reg_addr),
    .reg_wdata_i(reg_wdata), .reg_rdata_o(reg_rdata), .reg_error_o(reg_error),
    .host_req_i(host_req), .host_we_i(host_we), .host_addr_i(host_addr),
    .host_wdata_i(host_wdata), .host_gnt_o(host_gnt), .host_rvalid_o(host_rvalid),
    .host_rdata_o(host_rdata), .intr_o(intr)
  );

  initial begin
    clk = 1'b0;
    forever #(CLK_PERIOD / 2) clk = ~clk;
  end

  always @(posedge clk) cycle_cnt <= cycle_cnt + 1;

  initial begin
    repeat (WATCHDOG_CYCLES) @(posedge clk);
    $display("watchdog: run did not finish within %0d cycles", WATCHDOG_CYCLES);
    $display("TEST FAIL");
    $finish;
  end

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("error %s: %s expected %08h actual %08h", test_name, what, expected, actual);
      test_errors++;
    end
  endtask

  // Expected destination word of a job, from the source word in the model
  function automatic logic [31:0] ref_word(input int src_idx, input bit scale,
                                           input logic [31:0] factor);
    logic [31:0] word;
    word = model[src_idx];
    if (scale) word = word * factor;
    return word;
  endfunction

  always @(negedge clk) begin : read_monitor
    logic [31:0] exp_word;
    int          gnt_cycle;
    if (rst_n === 1'b1 && host_rvalid) begin
      if (exp_q.size() == 0) begin
        $display("error %s: host read data arrived with no read outstanding", test_name);
        test_errors++;
      end else begin
        exp_word  = exp_q.pop_front();
        gnt_cycle = gnt_cycle_q.pop_front();
        check("host read data", exp_word, host_rdata);
        check("host read latency", ext_pkg::MEM_LATENCY, cycle_cnt - gnt_cycle);
      end
    end
  end

  // Request held until granted; grant is sampled well ahead of the rising edge
  task automatic host_access(input logic we, input int idx, input logic [31:0] wdata);
    @(negedge clk);
    host_req   = 1'b1;
    host_we    = we;
    host_addr  = idx * 4;
    host_wdata = wdata;
    #(CLK_PERIOD / 4);
    while (!host_gnt) begin
      @(negedge clk);
      #(CLK_PERIOD / 4);
    end
    if (we) begin
      model[idx] = wdata;
    end else begin
      exp_q.push_back(model[idx]);
      gnt_cycle_q.push_back(cycle_cnt);
    end
    @(negedge clk);
    host_req = 1'b0;
    host_we  = 1'b0;
  endtask

  task automatic host_write(input int idx, input logic [31:0] data);
    host_access(1'b1, idx, data);
  endtask

  task automatic host_read(input int idx);
    host_access(1'b0, idx, 32'h0);
  endtask

  task automatic reg_wr(input logic [31:0] addr, input logic [31:0] data);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_write = 1'b1;
    reg_addr  = addr;
    reg_wdata = data;
    @(negedge clk);
    reg_valid = 1'b0;
    reg_write = 1'b0;
  endtask

  task automatic reg_rd(input logic [31:0] addr, output logic [31:0] data, output logic err);
    @(negedge clk);
    reg_valid = 1'b1;
    reg_addr  = addr;
    #(CLK_PERIOD / 4);
    data = reg_rdata;
    err  = reg_error;
    @(negedge clk);
    reg_valid = 1'b0;
  endtask

  task automatic reg_check(input string what, input logic [31:0] addr,
                           input logic [31:0] expected);
    logic [31:0] data;
    logic        err;
    reg_rd(addr, data, err);
    check(what, expected, data);
    check({what, " error flag"}, 32'h0, 32'(err));
  endtask

  task automatic reg_roundtrip(input string what, input logic [31:0] addr,
                               input logic [31:0] value);
    reg_wr(addr, value);
    reg_check(what, addr, value);
  endtask

  task automatic start_job(input logic [31:0] base, input int src, input int dst,
                           input int len, input logic [31:0] factor);
    reg_wr(base + ext_pkg::REG_SRC, src * 4);
    reg_wr(base + ext_pkg::REG_DST, dst * 4);
    reg_wr(base + ext_pkg::REG_LEN, len);
    if (base == ext_pkg::SCALER_BASE) reg_wr(base + ext_pkg::REG_FACTOR, factor);
    reg_wr(base + ext_pkg::REG_CTRL, 32'h1);
  endtask

  task automatic wait_done(input int irq_bit, input logic [31:0] base);
    while (!intr[irq_bit]) @(negedge clk);
    // Done set, busy clear
    reg_check("status", base + ext_pkg::REG_STATUS, 32'h2);
  endtask

  task automatic apply_job(input int src, input int dst, input int len, input bit scale,
                           input logic [31:0] factor);
    for (int i = 0; i < len; i++) model[dst + i] = ref_word(src + i, scale, factor);
  endtask

  task automatic fill(input int idx, input int len);
    for (int i = 0; i < len; i++) host_write(idx + i, $random(seed));
  endtask

  task automatic read_region(input int idx, input int len);
    for (int i = 0; i < len; i++) host_read(idx + i);
  endtask

  task automatic begin_test(input string name);
    test_name   = name;
    test_errors = 0;
  endtask

  task automatic end_test();
    while (exp_q.size() != 0) @(negedge clk);
    tests_run++;
    if (test_errors != 0) tests_failed++;
    total_errors += test_errors;
    $display("%-12s %s, %0d mismatches", test_name,
             (test_errors == 0) ? "ok" : "failed", test_errors);
  endtask

  initial begin
    logic [31:0] factor;
    logic [31:0] rdata;
    logic        err;
    rst_n        = 1'b0;
    reg_valid    = 1'b0;
    reg_write    = 1'b0;
    reg_addr     = '0;
    reg_wdata    = '0;
    host_req     = 1'b0;
    host_we      = 1'b0;
    host_addr    = '0;
    host_wdata   = '0;
    total_errors = 0;
    tests_run    = 0;
    tests_failed = 0;
    begin_test("reset");
    repeat (5) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    check("intr after reset", 32'h0, 32'(intr));
    check("host grant after reset", 32'h0, 32'(host_gnt));
    check("host rvalid after reset", 32'h0, 32'(host_rvalid));
    reg_check("dma status after reset", ext_pkg::DMA_BASE + ext_pkg::REG_STATUS, 32'h0);
    reg_check("scaler status after reset",
              ext_pkg::SCALER_BASE + ext_pkg::REG_STATUS, 32'h0);
    end_test();

    begin_test("host");
    fill(HOST_IDX, HOST_WORDS);
    read_region(HOST_IDX, HOST_WORDS);
    end_test();

    begin_test("copy");
    fill(COPY_SRC, COPY_LEN);
    start_job(ext_pkg::DMA_BASE, COPY_SRC, COPY_DST, COPY_LEN, 32'h0);
    check("intr after start", 32'h0, 32'(intr[0]));
    wait_done(0, ext_pkg::DMA_BASE);
    apply_job(COPY_SRC, COPY_DST, COPY_LEN, 1'b0, 32'h0);
    read_region(COPY_DST, COPY_LEN);
    end_test();

    begin_test("scale");
    factor = $random(seed);
    fill(SCALE_SRC, SCALE_LEN);
    start_job(ext_pkg::SCALER_BASE, SCALE_SRC, SCALE_DST, SCALE_LEN, factor);
    check("intr after start", 32'h0, 32'(intr[1]));
    wait_done(1, ext_pkg::SCALER_BASE);
    apply_job(SCALE_SRC, SCALE_DST, SCALE_LEN, 1'b1, factor);
    read_region(SCALE_DST, SCALE_LEN);
    end_test();

    // Host traffic on its own region competes with both engines
    begin_test("parallel");
    factor = $random(seed);
    start_job(ext_pkg::DMA_BASE, COPY_SRC, PAR_COPY_DST, COPY_LEN, 32'h0);
    start_job(ext_pkg::SCALER_BASE, SCALE_SRC, PAR_SCALE_DST, SCALE_LEN, factor);
    check("intr after start", 32'h0, 32'(intr));
    read_region(HOST_IDX, HOST_WORDS);
    wait_done(0, ext_pkg::DMA_BASE);
    wait_done(1, ext_pkg::SCALER_BASE);
    apply_job(COPY_SRC, PAR_COPY_DST, COPY_LEN, 1'b0, 32'h0);
    apply_job(SCALE_SRC, PAR_SCALE_DST, SCALE_LEN, 1'b1, factor);
    read_region(PAR_COPY_DST, COPY_LEN);
    read_region(PAR_SCALE_DST, SCALE_LEN);
    end_test();

    begin_test("registers");
    reg_roundtrip("dma src", ext_pkg::DMA_BASE + ext_pkg::REG_SRC, $random(seed));
    reg_roundtrip("dma dst", ext_pkg::DMA_BASE + ext_pkg::REG_DST, $random(seed));
    reg_roundtrip("dma len", ext_pkg::DMA_BASE + ext_pkg::REG_LEN, $random(seed) & 32'hffff);
    reg_roundtrip("scaler src", ext_pkg::SCALER_BASE + ext_pkg::REG_SRC, $random(seed));
    reg_roundtrip("scaler dst", ext_pkg::SCALER_BASE + ext_pkg::REG_DST, $random(seed));
    reg_roundtrip("scaler len", ext_pkg::SCALER_BASE + ext_pkg::REG_LEN,
                  $random(seed) & 32'hffff);
    reg_roundtrip("scaler factor", ext_pkg::SCALER_BASE + ext_pkg::REG_FACTOR, $random(seed));
    reg_rd(32'h0000_0200, rdata, err);
    check("unmapped data", 32'h0, rdata);
    check("unmapped error flag", 32'h1, 32'(err));
    end_test();

    begin_test("zero length");
    start_job(ext_pkg::DMA_BASE, SCALE_SRC, COPY_DST, 0, 32'h0);
    wait_done(0, ext_pkg::DMA_BASE);
    read_region(COPY_DST, ZERO_WORDS);
    end_test();

    $display("%0d tests, %0d failed, %0d errors", tests_run, tests_failed, total_errors);
    if (total_errors == 0) begin
      $display("TEST PASS");
    end else begin
      $display("TEST FAIL");
    end
    $finish;
  end

endmodule
